// File: Bender.yml
package:
  name: ula_video

sources:
  - files:
      - logic/ulaPkg.sv
      - logic/ulaApbRegs.sv
      - logic/paletteRam.sv
      - logic/attrDecode.sv
      - logic/pixelExecute.sv
      - logic/colourResult.sv
      - logic/ulaVideo.sv
  - target: simulation
    files:
      - verification/ulaVideo_assertions.sv
      - verification/ulaVideoTb.sv

// File: logic/attrDecode.sv
`timescale 1ns/1ps

module attrDecode (
   input  logic                              sysclk,
   input  logic                              rst_n,
   input  logic                              cellValid,
   input  logic [ulaPkg::byteW-1:0]          cellBitmap,
   input  ulaPkg::attrWord_u                 cellAttr,
   input  logic                              decTake,
   input  logic [ulaPkg::byteW-1:0]          paperEntry,
   input  logic [ulaPkg::byteW-1:0]          inkEntry,
   output logic                              cellReady,
   output logic [ulaPkg::paletteAddrW-1:0]   paperAddr,
   output logic [ulaPkg::paletteAddrW-1:0]   inkAddr,
   output logic                              decValid,
   output logic [ulaPkg::byteW-1:0]          decBitmap,
   output ulaPkg::attrWord_u                 decStd,
   output logic [ulaPkg::byteW-1:0]          decPlusPaper,
   output logic [ulaPkg::byteW-1:0]          decPlusInk
);
   import ulaPkg::*;

   logic cellAccept;

   // Palette index is group, paper/ink select, colour index
   assign paperAddr = {cellAttr.plusView.group, 1'b1, cellAttr.plusView.paperIdx};
   assign inkAddr = {cellAttr.plusView.group, 1'b0, cellAttr.plusView.inkIdx};

   // Free slot, or slot drained by execute this cycle
   assign cellReady = ~decValid | decTake;
   assign cellAccept = cellValid & cellReady;

   // Decode valid bit
   always_ff @(posedge sysclk) begin
      if (!rst_n)
         decValid <= 1'b0;
      else if (cellAccept)
         decValid <= 1'b1;
      else if (decTake)
         decValid <= 1'b0;
   end

   // Cell payload with both palette entries captured at accept
   always_ff @(posedge sysclk) begin
      if (cellAccept) begin
         decBitmap <= cellBitmap;
         decStd <= cellAttr;
         decPlusPaper <= paperEntry;
         decPlusInk <= inkEntry;
      end
   end

endmodule

// File: logic/colourResult.sv
`timescale 1ns/1ps

module colourResult (
   input  logic                        exValid,
   input  logic                        exInk,
   input  logic                        exRawPixel,
   input  logic                        exBright,
   input  logic [ulaPkg::chanW-1:0]    exPaper,
   input  logic [ulaPkg::chanW-1:0]    exInkColour,
   input  logic [ulaPkg::byteW-1:0]    exPlusPaper,
   input  logic [ulaPkg::byteW-1:0]    exPlusInk,
   input  logic                        plusMode,
   output logic                        pixelValid,
   output logic [ulaPkg::chanW-1:0]    red,
   output logic [ulaPkg::chanW-1:0]    green,
   output logic [ulaPkg::chanW-1:0]    blue
);
   import ulaPkg::*;

   logic [chanW-1:0] stdColour;
   logic [chanW-1:0] stdLevel;
   logic [byteW-1:0] plusEntry;

   assign pixelValid = exValid;

   // Spectrum colour is GRB, flash already folded into exInk
   assign stdColour = exInk ? exInkColour : exPaper;
   assign stdLevel = exBright ? levelFull : levelHalf;

   // ULAplus ignores flash
   assign plusEntry = exRawPixel ? exPlusInk : exPlusPaper;

   ////////////////////////////////////////
   // Channel mapping
   ////////////////////////////////////////

   always_comb begin
      if (plusMode) begin
         // GGGRRRBB, third blue bit is B1 | B0
         green = plusEntry[7:5];
         red = plusEntry[4:2];
         blue = {plusEntry[1:0], |plusEntry[1:0]};
      end else begin
         // Black stays black with bright
         green = stdColour[2] ? stdLevel : levelNone;
         red = stdColour[1] ? stdLevel : levelNone;
         blue = stdColour[0] ? stdLevel : levelNone;
      end
   end

endmodule

// File: logic/paletteRam.sv
`timescale 1ns/1ps

module paletteRam (
   input  logic                              sysclk,
   input  logic                              wrEn,
   input  logic [ulaPkg::paletteAddrW-1:0]   wrAddr,
   input  logic [ulaPkg::byteW-1:0]          wrData,
   input  logic [ulaPkg::paletteAddrW-1:0]   cpuAddr,
   input  logic [ulaPkg::paletteAddrW-1:0]   paperAddr,
   input  logic [ulaPkg::paletteAddrW-1:0]   inkAddr,
   output logic [ulaPkg::byteW-1:0]          cpuData,
   output logic [ulaPkg::byteW-1:0]          paperEntry,
   output logic [ulaPkg::byteW-1:0]          inkEntry
);
   import ulaPkg::*;

   // GGGRRRBB entries
   logic [byteW-1:0] entries [2**paletteAddrW];

   // Single CPU write port
   always_ff @(posedge sysclk) begin
      if (wrEn)
         entries[wrAddr] <= wrData;
   end

   ////////////////////////////////////////
   // Asynchronous lookups
   ////////////////////////////////////////

   // CPU readback
   assign cpuData = entries[cpuAddr];
   // Paper and ink for the cell in decode
   assign paperEntry = entries[paperAddr];
   assign inkEntry = entries[inkAddr];

endmodule

// File: logic/pixelExecute.sv
`timescale 1ns/1ps

module pixelExecute (
   input  logic                        sysclk,
   input  logic                        rst_n,
   input  logic                        frameStart,
   input  logic                        decValid,
   input  logic [ulaPkg::byteW-1:0]    decBitmap,
   input  ulaPkg::attrWord_u           decStd,
   input  logic [ulaPkg::byteW-1:0]    decPlusPaper,
   input  logic [ulaPkg::byteW-1:0]    decPlusInk,
   output logic                        decTake,
   output logic                        exValid,
   output logic                        exInk,
   output logic                        exRawPixel,
   output logic                        exBright,
   output logic [ulaPkg::chanW-1:0]    exPaper,
   output logic [ulaPkg::chanW-1:0]    exInkColour,
   output logic [ulaPkg::byteW-1:0]    exPlusPaper,
   output logic [ulaPkg::byteW-1:0]    exPlusInk
);
   import ulaPkg::*;

   logic [byteW-1:0] shiftReg;
   logic [cellPosW-1:0] pixelPos;
   logic [flashDivW-1:0] flashCount;
   attrWord_u exAttr;
   logic lastPixel;

   ////////////////////////////////////////
   // Serializer
   ////////////////////////////////////////

   assign lastPixel = (pixelPos == cellPosW'(cellPixels - 1));
   // Take the next cell when idle or on the final bit
   assign decTake = decValid & (~exValid | lastPixel);

   always_ff @(posedge sysclk) begin
      if (!rst_n) begin
         exValid <= 1'b0;
         pixelPos <= '0;
      end else if (decTake) begin
         exValid <= 1'b1;
         pixelPos <= '0;
      end else if (exValid) begin
         pixelPos <= pixelPos + 1'b1;
         // Drop out after bit 0 with nothing queued
         if (lastPixel)
            exValid <= 1'b0;
      end
   end

   // Bitmap shifts MSB first, attributes ride along
   always_ff @(posedge sysclk) begin
      if (decTake) begin
         shiftReg <= decBitmap;
         exAttr <= decStd;
         exPlusPaper <= decPlusPaper;
         exPlusInk <= decPlusInk;
      end else begin
         shiftReg <= {shiftReg[byteW-2:0], 1'b0};
      end
   end

   ////////////////////////////////////////
   // Flash
   ////////////////////////////////////////

   // Phase toggles every 16 frames
   always_ff @(posedge sysclk) begin
      if (!rst_n)
         flashCount <= '0;
      else if (frameStart)
         flashCount <= flashCount + 1'b1;
   end

   assign exRawPixel = shiftReg[byteW-1];
   assign exInk = exRawPixel ^ (exAttr.stdView.flash & flashCount[flashDivW-1]);
   assign exBright = exAttr.stdView.bright;
   assign exPaper = exAttr.stdView.paper;
   assign exInkColour = exAttr.stdView.ink;

endmodule

// File: logic/ulaApbRegs.sv
`timescale 1ns/1ps

module ulaApbRegs (
   input  logic                              sysclk,
   input  logic                              rst_n,
   input  logic                              psel,
   input  logic                              penable,
   input  logic                              pwrite,
   input  logic [ulaPkg::portAddrW-1:0]      paddr,
   input  logic [ulaPkg::byteW-1:0]          pwdata,
   input  logic [ulaPkg::byteW-1:0]          paletteCpuData,
   output logic [ulaPkg::byteW-1:0]          prdata,
   output logic                              pready,
   output logic                              pslverr,
   output logic                              mic,
   output logic                              spk,
   output logic                              plusMode,
   output logic                              paletteWrEn,
   output logic [ulaPkg::paletteAddrW-1:0]   paletteWrAddr,
   output logic [ulaPkg::byteW-1:0]          paletteWrData,
   output logic [ulaPkg::paletteAddrW-1:0]   paletteCpuAddr
);
   import ulaPkg::*;

   // ULAplus address register, bit 6 picks the mode register
   logic [paletteAddrW:0] plusAddrReg;

   ////////////////////////////////////////
   // Address decode
   ////////////////////////////////////////

   logic accessPhase;
   logic writeAccess;
   logic isPortFe;
   logic isAddrPort;
   logic isDataPort;

   assign accessPhase = psel & penable;
   assign writeAccess = accessPhase & pwrite;
   assign isAddrPort = (paddr == ulaPlusAddrPort);
   assign isDataPort = (paddr == ulaPlusDataPort);
   // Any even address hits the ULA
   assign isPortFe = ~paddr[0];

   // No wait states
   assign pready = 1'b1;
   // Odd addresses outside ULAplus are not mapped
   assign pslverr = accessPhase & paddr[0] & ~isAddrPort & ~isDataPort;

   ////////////////////////////////////////
   // Register writes
   ////////////////////////////////////////

   always_ff @(posedge sysclk) begin
      if (!rst_n) begin
         mic <= 1'b0;
         spk <= 1'b0;
         plusMode <= 1'b0;
         plusAddrReg <= '0;
      end else if (writeAccess) begin
         // Border bits are ignored here
         if (isPortFe) begin
            mic <= pwdata[3];
            spk <= pwdata[4];
         end
         if (isAddrPort)
            plusAddrReg <= pwdata[paletteAddrW:0];
         // Mode register sits behind the data port
         if (isDataPort && plusAddrReg[paletteAddrW])
            plusMode <= pwdata[0];
      end
   end

   // Palette write steered by address bit 6
   assign paletteWrEn = writeAccess & isDataPort & ~plusAddrReg[paletteAddrW];
   assign paletteWrAddr = plusAddrReg[paletteAddrW-1:0];
   assign paletteWrData = pwdata;
   assign paletteCpuAddr = plusAddrReg[paletteAddrW-1:0];

   ////////////////////////////////////////
   // Read data
   ////////////////////////////////////////

   always_comb begin
      prdata = 8'hFF;
      if (isAddrPort)
         prdata = {1'b0, plusAddrReg};
      else if (isDataPort && plusAddrReg[paletteAddrW])
         prdata = {7'b0000000, plusMode};
      else if (isDataPort)
         prdata = paletteCpuData;
   end

endmodule

// File: logic/ulaPkg.sv
package ulaPkg;

   ////////////////////////////////////////
   // CPU port map
   ////////////////////////////////////////

   // Z80 style I/O address and data widths
   localparam int portAddrW = 16;
   localparam int byteW = 8;

   // ULAplus register ports, both odd
   // Port FE is decoded from any even address
   localparam logic [portAddrW-1:0] ulaPlusAddrPort = 16'hBF3B;
   localparam logic [portAddrW-1:0] ulaPlusDataPort = 16'hFF3B;

   ////////////////////////////////////////
   // Colour
   ////////////////////////////////////////

   // One GRB channel of the 9-bit output
   localparam int chanW = 3;

   // Standard mode channel levels
   localparam logic [chanW-1:0] levelNone = 3'b000;
   localparam logic [chanW-1:0] levelHalf = 3'b101;
   localparam logic [chanW-1:0] levelFull = 3'b111;

   // ULAplus palette holds 64 GGGRRRBB entries
   localparam int paletteAddrW = 6;

   ////////////////////////////////////////
   // Pixel timing
   ////////////////////////////////////////

   localparam int cellPixels = 8;
   localparam int cellPosW = $clog2(cellPixels);

   // Frame pulse divider, MSB is the flash phase
   localparam int flashDivW = 5;

   // Attribute byte, read as Spectrum colours or as ULAplus palette indices
   typedef union packed {
      struct packed {
         logic             flash;
         logic             bright;
         logic [chanW-1:0] paper;
         logic [chanW-1:0] ink;
      } stdView;
      struct packed {
         logic [1:0]       group;
         logic [chanW-1:0] paperIdx;
         logic [chanW-1:0] inkIdx;
      } plusView;
   } attrWord_u;

endpackage

// File: logic/ulaVideo.sv
`timescale 1ns/1ps

module ulaVideo (
   input  logic                           sysclk,
   input  logic                           rst_n,
   // APB slave
   input  logic                           psel,
   input  logic                           penable,
   input  logic                           pwrite,
   input  logic [ulaPkg::portAddrW-1:0]   paddr,
   input  logic [ulaPkg::byteW-1:0]       pwdata,
   output logic [ulaPkg::byteW-1:0]       prdata,
   output logic                           pready,
   output logic                           pslverr,
   output logic                           mic,
   output logic                           spk,
   // Cells in
   input  logic                           cellValid,
   input  logic [ulaPkg::byteW-1:0]       cellBitmap,
   input  ulaPkg::attrWord_u              cellAttr,
   output logic                           cellReady,
   // Pixels out
   input  logic                           frameStart,
   output logic                           pixelValid,
   output logic [ulaPkg::chanW-1:0]       red,
   output logic [ulaPkg::chanW-1:0]       green,
   output logic [ulaPkg::chanW-1:0]       blue
);
   import ulaPkg::*;

   // CPU side of the palette
   logic plusMode;
   logic paletteWrEn;
   logic [paletteAddrW-1:0] paletteWrAddr;
   logic [byteW-1:0] paletteWrData;
   logic [paletteAddrW-1:0] paletteCpuAddr;
   logic [byteW-1:0] paletteCpuData;

   // Decode lookups
   logic [paletteAddrW-1:0] paperAddr;
   logic [paletteAddrW-1:0] inkAddr;
   logic [byteW-1:0] paperEntry;
   logic [byteW-1:0] inkEntry;

   // Decode to execute
   logic decValid;
   logic decTake;
   logic [byteW-1:0] decBitmap;
   attrWord_u decStd;
   logic [byteW-1:0] decPlusPaper;
   logic [byteW-1:0] decPlusInk;

   // Execute to result
   logic exValid;
   logic exInk;
   logic exRawPixel;
   logic exBright;
   logic [chanW-1:0] exPaper;
   logic [chanW-1:0] exInkColour;
   logic [byteW-1:0] exPlusPaper;
   logic [byteW-1:0] exPlusInk;

   ////////////////////////////////////////
   // CPU registers and palette
   ////////////////////////////////////////

   ulaApbRegs apbRegs (
      .sysclk         (sysclk),
      .rst_n          (rst_n),
      .psel           (psel),
      .penable        (penable),
      .pwrite         (pwrite),
      .paddr          (paddr),
      .pwdata         (pwdata),
      .paletteCpuData (paletteCpuData),
      .prdata         (prdata),
      .pready         (pready),
      .pslverr        (pslverr),
      .mic            (mic),
      .spk            (spk),
      .plusMode       (plusMode),
      .paletteWrEn    (paletteWrEn),
      .paletteWrAddr  (paletteWrAddr),
      .paletteWrData  (paletteWrData),
      .paletteCpuAddr (paletteCpuAddr)
   );

   paletteRam palette (
      .sysclk     (sysclk),
      .wrEn       (paletteWrEn),
      .wrAddr     (paletteWrAddr),
      .wrData     (paletteWrData),
      .cpuAddr    (paletteCpuAddr),
      .paperAddr  (paperAddr),
      .inkAddr    (inkAddr),
      .cpuData    (paletteCpuData),
      .paperEntry (paperEntry),
      .inkEntry   (inkEntry)
   );

   ////////////////////////////////////////
   // Pixel pipeline
   ////////////////////////////////////////

   attrDecode decode (
      .sysclk       (sysclk),
      .rst_n        (rst_n),
      .cellValid    (cellValid),
      .cellBitmap   (cellBitmap),
      .cellAttr     (cellAttr),
      .decTake      (decTake),
      .paperEntry   (paperEntry),
      .inkEntry     (inkEntry),
      .cellReady    (cellReady),
      .paperAddr    (paperAddr),
      .inkAddr      (inkAddr),
      .decValid     (decValid),
      .decBitmap    (decBitmap),
      .decStd       (decStd),
      .decPlusPaper (decPlusPaper),
      .decPlusInk   (decPlusInk)
   );

   pixelExecute execute (
      .sysclk       (sysclk),
      .rst_n        (rst_n),
      .frameStart   (frameStart),
      .decValid     (decValid),
      .decBitmap    (decBitmap),
      .decStd       (decStd),
      .decPlusPaper (decPlusPaper),
      .decPlusInk   (decPlusInk),
      .decTake      (decTake),
      .exValid      (exValid),
      .exInk        (exInk),
      .exRawPixel   (exRawPixel),
      .exBright     (exBright),
      .exPaper      (exPaper),
      .exInkColour  (exInkColour),
      .exPlusPaper  (exPlusPaper),
      .exPlusInk    (exPlusInk)
   );

   colourResult result (
      .exValid     (exValid),
      .exInk       (exInk),
      .exRawPixel  (exRawPixel),
      .exBright    (exBright),
      .exPaper     (exPaper),
      .exInkColour (exInkColour),
      .exPlusPaper (exPlusPaper),
      .exPlusInk   (exPlusInk),
      .plusMode    (plusMode),
      .pixelValid  (pixelValid),
      .red         (red),
      .green       (green),
      .blue        (blue)
   );

endmodule

// File: ulaVideo.f
logic/ulaPkg.sv
logic/ulaApbRegs.sv
logic/paletteRam.sv
logic/attrDecode.sv
logic/pixelExecute.sv
logic/colourResult.sv
logic/ulaVideo.sv
verification/ulaVideo_assertions.sv
verification/ulaVideoTb.sv

// File: verification/ulaVideoTb.sv
`timescale 1ns/1ps

module ulaVideoTb;
   import ulaPkg::*;

   // Around 400 cells plus the APB phases, with margin
   localparam int cycleLimit = 20000;
   localparam int randomCells = 150;

   logic sysclk;
   logic rst_n;
   logic psel;
   logic penable;
   logic pwrite;
   logic [portAddrW-1:0] paddr;
   logic [byteW-1:0] pwdata;
   logic [byteW-1:0] prdata;
   logic pready;
   logic pslverr;
   logic mic;
   logic spk;
   logic cellValid;
   logic [byteW-1:0] cellBitmap;
   attrWord_u cellAttr;
   logic cellReady;
   logic frameStart;
   logic pixelValid;
   logic [chanW-1:0] red;
   logic [chanW-1:0] green;
   logic [chanW-1:0] blue;

   // Reference model state
   logic [31:0] lfsrState;
   logic [7:0] modelPalette [64];
   logic modelPlus;
   int modelFrames;
   // Expected {green, red, blue} in display order
   logic [8:0] expQ [$];

   int cycles;
   int checks;
   int errors;
   // Back-to-back stream tracking
   logic burstCheck;
   logic burstStarted;
   logic burstSawPixel;
   int burstAcceptCycle;

   ulaVideo DUT (.*);

   initial sysclk = 1'b0;
   always #5 sysclk = ~sysclk;

   ////////////////////////////////////////
   // Random source and colour model
   ////////////////////////////////////////

   // Taps 32 22 2 1, one step per bit taken
   function automatic logic [31:0] randBits(input int n);
      logic [31:0] val;
      logic fb;
      int i;
      val = '0;
      for (i = 0; i < n; i++) begin
         fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
         lfsrState = {lfsrState[30:0], fb};
         val = {val[30:0], fb};
      end
      return val;
   endfunction

   // Each set GRB bit gets half level, or full with bright
   function automatic logic [8:0] standardRgb(input logic [2:0] colour, input logic bright);
      logic [2:0] level;
      level = bright ? 3'b111 : 3'b101;
      return {colour[2] ? level : 3'b000, colour[1] ? level : 3'b000,
              colour[0] ? level : 3'b000};
   endfunction

   // GGGRRRBB to nine bits, third blue bit is the OR
   function automatic logic [8:0] spreadEntry(input logic [7:0] e);
      return {e[7:5], e[4:2], e[1:0], e[1] | e[0]};
   endfunction

   // Eight pixels of one accepted cell, bit 7 first
   function automatic void expectCell(input logic [7:0] bitmap, input logic [7:0] attr);
      logic [5:0] paperIdx;
      logic [5:0] inkIdx;
      logic phase;
      logic pix;
      int k;
      paperIdx = {attr[7:6], 1'b1, attr[5:3]};
      inkIdx = {attr[7:6], 1'b0, attr[2:0]};
      // Phase is bit 4 of the frame count
      phase = modelFrames[4];
      for (k = 7; k >= 0; k--) begin
         pix = bitmap[k];
         if (modelPlus)
            expQ.push_back(spreadEntry(pix ? modelPalette[inkIdx] : modelPalette[paperIdx]));
         else if (pix ^ (attr[7] & phase))
            expQ.push_back(standardRgb(attr[2:0], attr[6]));
         else
            expQ.push_back(standardRgb(attr[5:3], attr[6]));
      end
   endfunction

   ////////////////////////////////////////
   // APB and cell drivers
   ////////////////////////////////////////

   // One setup and one access phase, pslverr checked in the access phase
   task automatic busTransfer(input logic wr, input logic [15:0] addr,
                              input logic [7:0] wdata, output logic [7:0] rdata);
      logic expErr;
      expErr = addr[0] && addr != ulaPlusAddrPort && addr != ulaPlusDataPort;
      @(posedge sysclk);
      psel <= 1'b1;
      penable <= 1'b0;
      pwrite <= wr;
      paddr <= addr;
      pwdata <= wdata;
      @(posedge sysclk);
      penable <= 1'b1;
      @(negedge sysclk);
      while (!pready) @(negedge sysclk);
      rdata = prdata;
      checks++;
      if (pslverr !== expErr) begin
         errors++;
         $display("mismatch at %0t: pslverr %b expected %b at %h", $time, pslverr, expErr, addr);
      end
      @(posedge sysclk);
      psel <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic writePort(input logic [15:0] addr, input logic [7:0] data);
      logic [7:0] unused;
      busTransfer(1'b1, addr, data, unused);
   endtask

   task automatic readPort(input logic [15:0] addr, input logic [7:0] expected);
      logic [7:0] got;
      busTransfer(1'b0, addr, 8'h00, got);
      checks++;
      if (got !== expected) begin
         errors++;
         $display("mismatch at %0t: prdata %h expected %h at %h", $time, got, expected, addr);
      end
   endtask

   // Mode register sits behind address bit 6
   task automatic setMode(input logic plus);
      writePort(ulaPlusAddrPort, 8'h40);
      writePort(ulaPlusDataPort, {7'b0000000, plus});
      modelPlus = plus;
      readPort(ulaPlusDataPort, {7'b0000000, plus});
   endtask

   // Returns on the negedge before the accepting edge
   task automatic sendCell(input logic [7:0] bitmap, input logic [7:0] attr);
      @(posedge sysclk);
      cellValid <= 1'b1;
      cellBitmap <= bitmap;
      cellAttr <= attr;
      @(negedge sysclk);
      while (!cellReady) @(negedge sysclk);
   endtask

   task automatic idleCycles(input int n);
      repeat (n) begin
         @(posedge sysclk);
         cellValid <= 1'b0;
      end
   endtask

   task automatic sendRandomCells(input int count, input logic [7:0] attrSet,
                                  input logic withGaps);
      int n;
      for (n = 0; n < count; n++) begin
         sendCell(8'(randBits(8)), 8'(randBits(8)) | attrSet);
         if (withGaps)
            idleCycles(int'(randBits(2)));
      end
   endtask

   task automatic drainPixels();
      @(posedge sysclk);
      cellValid <= 1'b0;
      @(negedge sysclk);
      while (expQ.size() != 0) @(negedge sysclk);
      repeat (2) @(posedge sysclk);
   endtask

   task automatic pulseFrames(input int n);
      repeat (n) begin
         @(posedge sysclk);
         frameStart <= 1'b1;
         @(posedge sysclk);
         frameStart <= 1'b0;
      end
      modelFrames += n;
   endtask

   ////////////////////////////////////////
   // Pixel monitor
   ////////////////////////////////////////

   always @(negedge sysclk) begin
      if (rst_n) begin
         if (pixelValid && expQ.size() == 0) begin
            errors++;
            $display("unexpected pixel at %0t with no cell accepted", $time);
         end else if (pixelValid) begin
            checks++;
            if ({green, red, blue} !== expQ[0]) begin
               errors++;
               $display("mismatch at %0t: pixel grb %h expected %h", $time,
                        {green, red, blue}, expQ[0]);
            end
            void'(expQ.pop_front());
         end
         // First burst pixel two cycles after the first accept
         if (burstCheck && pixelValid && !burstSawPixel) begin
            burstSawPixel = 1'b1;
            if (cycles - burstAcceptCycle != 2) begin
               errors++;
               $display("mismatch at %0t: first pixel after %0d cycles, expected 2", $time,
                        cycles - burstAcceptCycle);
            end
         end
         if (burstCheck && burstSawPixel && !pixelValid && expQ.size() != 0) begin
            errors++;
            $display("pixel stream stalled at %0t during back-to-back cells", $time);
         end
         if (burstCheck && !burstStarted && cellValid && cellReady) begin
            burstStarted = 1'b1;
            burstAcceptCycle = cycles;
         end
         if (cellValid && cellReady)
            expectCell(cellBitmap, cellAttr);
      end
   end

   // Run limit
   always @(posedge sysclk) begin
      cycles <= cycles + 1;
      if (cycles >= cycleLimit) begin
         $display("timeout after %0d cycles with %0d errors", cycles, errors);
         $display("sim failed");
         $finish;
      end
   end

   ////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////

   initial begin
      int i;
      logic [7:0] d;
      logic [15:0] a;
      lfsrState = 32'h71d5526e;
      rst_n = 1'b0;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
      paddr = '0;
      pwdata = '0;
      cellValid = 1'b0;
      cellBitmap = '0;
      cellAttr = '0;
      frameStart = 1'b0;
      modelPlus = 1'b0;
      modelFrames = 0;
      cycles = 0;
      checks = 0;
      errors = 0;
      burstCheck = 1'b0;
      burstStarted = 1'b0;
      burstSawPixel = 1'b0;
      burstAcceptCycle = 0;
      repeat (16) @(posedge sysclk);
      rst_n <= 1'b1;

      // Address register reads back with bit 7 clear
      d = 8'(randBits(8));
      writePort(ulaPlusAddrPort, d);
      readPort(ulaPlusAddrPort, {1'b0, d[6:0]});
      setMode(1'b1);
      setMode(1'b0);

      // Fill all 64 palette entries, then read them back
      for (i = 0; i < 64; i++) begin
         d = 8'(randBits(8));
         writePort(ulaPlusAddrPort, 8'(i));
         writePort(ulaPlusDataPort, d);
         modelPalette[i] = d;
      end
      for (i = 0; i < 64; i++) begin
         writePort(ulaPlusAddrPort, 8'(i));
         readPort(ulaPlusDataPort, modelPalette[i]);
      end

      // Unmapped odd ports, alternating read and write
      for (i = 0; i < 8; i++) begin
         a = 16'(randBits(16)) | 16'h0001;
         if (a == ulaPlusAddrPort || a == ulaPlusDataPort)
            a = a ^ 16'h0100;
         busTransfer(i[0], a, 8'(randBits(8)), d);
      end

      // Port FE on random even addresses
      for (i = 0; i < 6; i++) begin
         a = 16'(randBits(16)) & 16'hFFFE;
         d = 8'(randBits(8));
         writePort(a, d);
         @(negedge sysclk);
         checks++;
         if (mic !== d[3] || spk !== d[4]) begin
            errors++;
            $display("mismatch at %0t: mic spk %b%b expected %b%b", $time, mic, spk, d[3], d[4]);
         end
         readPort(a, 8'hFF);
      end

      // Standard colours with idle gaps
      sendRandomCells(randomCells, 8'h00, 1'b1);
      drainPixels();

      // Flashing cells at phase 0, 1 and back to 0
      for (i = 0; i < 3; i++) begin
         sendRandomCells(16, 8'h80, 1'b1);
         drainPixels();
         pulseFrames(16);
      end

      // ULAplus palette lookup, flash phase is now set
      setMode(1'b1);
      sendRandomCells(randomCells, 8'h00, 1'b1);
      drainPixels();
      setMode(1'b0);

      // Unbroken stream with cellValid held high
      burstCheck = 1'b1;
      sendRandomCells(40, 8'h00, 1'b0);
      drainPixels();
      burstCheck = 1'b0;
      if (!burstSawPixel) begin
         errors++;
         $display("no pixels came out for the back-to-back cells");
      end

      $display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
               DUT.protocolChecks.assertFails);
      if (errors == 0 && DUT.protocolChecks.assertFails == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

// File: verification/ulaVideo_assertions.sv
`timescale 1ns/1ps

module ulaVideo_assertions (
   input  logic                        sysclk,
   input  logic                        rst_n,
   input  logic                        psel,
   input  logic                        penable,
   input  logic                        pready,
   input  logic                        pslverr,
   input  logic                        pixelValid,
   input  logic [ulaPkg::chanW-1:0]    red,
   input  logic [ulaPkg::chanW-1:0]    green,
   input  logic [ulaPkg::chanW-1:0]    blue
);

   // Failure count read by the testbench summary
   int assertFails = 0;

   // No wait states
   readyHigh: assert property (@(posedge sysclk) pready)
      else begin
         assertFails++;
         $error("pready dropped low");
      end

   // Slave error only in an access phase
   errInAccess: assert property (@(posedge sysclk) pslverr |-> (psel && penable))
      else begin
         assertFails++;
         $error("pslverr outside an APB access phase");
      end

   // Pipeline empty once reset has been seen
   quietInReset: assert property (@(posedge sysclk) !rst_n |=> !pixelValid)
      else begin
         assertFails++;
         $error("pixelValid high during reset");
      end

   colourKnown: assert property (@(posedge sysclk) pixelValid |-> !$isunknown({red, green, blue}))
      else begin
         assertFails++;
         $error("unknown colour on a valid pixel");
      end

endmodule

bind ulaVideo ulaVideo_assertions protocolChecks (
   .sysclk     (sysclk),
   .rst_n      (rst_n),
   .psel       (psel),
   .penable    (penable),
   .pready     (pready),
   .pslverr    (pslverr),
   .pixelValid (pixelValid),
   .red        (red),
   .green      (green),
   .blue       (blue)
);
